/* verilog/cache_pkg.sv */
// cache package: word, address and line widths plus the miss controller states
package cache_pkg;

	// ------------------------------------------------------------
	// processor side
	// ------------------------------------------------------------
	localparam int word_bits = 32;   // one data word
	localparam int addr_bits = 30;   // word address, no byte bits

	// ------------------------------------------------------------
	// line geometry
	// ------------------------------------------------------------
	localparam int line_words = 4;

	// word select inside a line
	localparam int offset_bits = $clog2(line_words);

	// a full line as the memory moves it
	localparam int line_bits = word_bits * line_words;

	// ------------------------------------------------------------
	// memory side
	// ------------------------------------------------------------

	// memory is addressed per line, so the word offset drops out
	localparam int mem_addr_bits = addr_bits - offset_bits;

	// ------------------------------------------------------------
	// miss controller
	// ------------------------------------------------------------

	// idle only follows reset; compare is the resting state where hits are
	// served, the other two each wait for one mem_ready
	typedef enum logic [1:0] {
		st_idle,        // single cycle after reset
		st_compare,     // tag check, hits done here
		st_write_back,  // dirty victim line out
		st_allocate     // requested line in
	} cache_state_t;

endpackage

/* verilog/cache_ways.sv */
// cache ways: two-way tag, state and line storage with hit lookup, victim choice and LRU
`timescale 1ns/10ps
module cache_ways #(
	parameter int set_bits = 2
) (
	input  logic                                                          clk,
	input  logic                                                          proc_reset,
	input  logic                                                          proc_read,
	input  logic [cache_pkg::addr_bits-1:0]                               proc_addr,
	input  logic [cache_pkg::word_bits-1:0]                               proc_wdata,
	input  logic [cache_pkg::line_bits-1:0]                               mem_rdata,
	input  logic                                                          write_word,
	input  logic                                                          fill_line,
	input  logic                                                          clean_victim,
	output logic                                                          hit,
	output logic [cache_pkg::word_bits-1:0]                               rdata,
	output logic                                                          victim_dirty,
	output logic [cache_pkg::addr_bits-cache_pkg::offset_bits-set_bits-1:0] victim_tag,
	output logic [cache_pkg::line_bits-1:0]                               victim_line
);
	import cache_pkg::*;

	localparam int tag_bits = addr_bits - offset_bits - set_bits;
	localparam int num_sets = 1 << set_bits;

	// ------------------------------------------------------------
	// storage, way first then set
	// ------------------------------------------------------------
	logic                 valid_q [2][num_sets];
	logic                 dirty_q [2][num_sets];
	logic [tag_bits-1:0]  tag_q   [2][num_sets];
	logic [line_bits-1:0] data_q  [2][num_sets];
	logic                 lru_q   [num_sets];   // way touched last

	// address split: tag | index | offset
	logic [offset_bits-1:0] offset;
	logic [set_bits-1:0]    index;
	logic [tag_bits-1:0]    tag;

	logic                 hit0;
	logic                 hit1;
	logic                 hit_way;
	logic                 victim_way;
	logic [line_bits-1:0] hit_line;

	assign offset = proc_addr[offset_bits-1:0];
	assign index  = proc_addr[offset_bits +: set_bits];
	assign tag    = proc_addr[addr_bits-1 -: tag_bits];

	// ------------------------------------------------------------
	// lookup
	// ------------------------------------------------------------
	assign hit0 = valid_q[0][index] && (tag_q[0][index] == tag);
	assign hit1 = valid_q[1][index] && (tag_q[1][index] == tag);
	assign hit  = hit0 | hit1;

	// a tag never sits in both ways, so way 1 hit alone picks the way
	assign hit_way  = hit1;
	assign hit_line = data_q[hit_way][index];
	assign rdata    = hit_line[offset*word_bits +: word_bits];

	// ------------------------------------------------------------
	// victim is the way not used last
	// ------------------------------------------------------------
	assign victim_way   = ~lru_q[index];
	assign victim_dirty = dirty_q[victim_way][index];   // only ever set on valid lines
	assign victim_tag   = tag_q[victim_way][index];
	assign victim_line  = data_q[victim_way][index];

	// ------------------------------------------------------------
	// line state and LRU
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < num_sets; s++) begin
				valid_q[0][s] <= 1'b0;
				valid_q[1][s] <= 1'b0;
				dirty_q[0][s] <= 1'b0;
				dirty_q[1][s] <= 1'b0;
				lru_q[s]      <= 1'b0;
			end
		end else begin
			// fill brings in a clean line and makes it most recent
			if (fill_line) begin
				valid_q[victim_way][index] <= 1'b1;
				dirty_q[victim_way][index] <= 1'b0;
				lru_q[index]               <= victim_way;
			end

			// victim copy now matches memory
			if (clean_victim) begin
				dirty_q[victim_way][index] <= 1'b0;
			end

			if (write_word) begin
				dirty_q[hit_way][index] <= 1'b1;   // line differs from memory now
			end

			// any hit, read or write, refreshes recency
			if (write_word || (proc_read && hit)) begin
				lru_q[index] <= hit_way;
			end
		end
	end

	// ------------------------------------------------------------
	// tags and line data
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (fill_line) begin
			tag_q[victim_way][index]  <= tag;
			data_q[victim_way][index] <= mem_rdata;
		end else if (write_word) begin
			data_q[hit_way][index][offset*word_bits +: word_bits] <= proc_wdata;
		end
	end

endmodule

/* verilog/cache_ctrl.sv */
// cache controller: miss FSM sequencing write-back and allocate, memory strobes and stall
`timescale 1ns/10ps
module cache_ctrl #(
	parameter int set_bits = 2
) (
	input  logic                                                          clk,
	input  logic                                                          proc_reset,
	input  logic                                                          proc_read,
	input  logic                                                          proc_write,
	input  logic [cache_pkg::addr_bits-1:0]                               proc_addr,
	input  logic                                                          hit,
	input  logic                                                          victim_dirty,
	input  logic [cache_pkg::addr_bits-cache_pkg::offset_bits-set_bits-1:0] victim_tag,
	input  logic [cache_pkg::line_bits-1:0]                               victim_line,
	input  logic                                                          mem_ready,
	output logic                                                          proc_stall,
	output logic                                                          write_word,
	output logic                                                          fill_line,
	output logic                                                          clean_victim,
	output logic                                                          mem_read,
	output logic                                                          mem_write,
	output logic [cache_pkg::mem_addr_bits-1:0]                           mem_addr,
	output logic [cache_pkg::line_bits-1:0]                               mem_wdata
);
	import cache_pkg::*;

	cache_state_t state_q;
	cache_state_t state_d;

	logic                     request;
	logic [set_bits-1:0]      index;
	logic [mem_addr_bits-1:0] line_addr;     // line the processor wants
	logic [mem_addr_bits-1:0] victim_addr;   // line being evicted

	assign request     = proc_read | proc_write;
	assign index       = proc_addr[offset_bits +: set_bits];
	assign line_addr   = proc_addr[addr_bits-1:offset_bits];
	assign victim_addr = {victim_tag, index};   // same set, stored tag

	// ------------------------------------------------------------
	// state register
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= st_idle;
		end else begin
			state_q <= state_d;
		end
	end

	// ------------------------------------------------------------
	// next state and outputs
	// ------------------------------------------------------------
	always_comb begin
		state_d      = state_q;
		proc_stall   = 1'b1;   // stalled unless compare says otherwise
		write_word   = 1'b0;
		fill_line    = 1'b0;
		clean_victim = 1'b0;
		mem_read     = 1'b0;
		mem_write    = 1'b0;
		mem_addr     = '0;
		mem_wdata    = '0;

		case (state_q)
			st_idle: begin
				state_d = st_compare;
			end

			st_compare: begin
				// hits finish in the request cycle
				proc_stall = request & ~hit;
				write_word = proc_write & hit;
				if (request && !hit) begin
					if (victim_dirty) begin
						state_d = st_write_back;
					end else begin
						state_d = st_allocate;   // clean victim, just overwrite
					end
				end
			end

			st_write_back: begin
				mem_write = 1'b1;
				mem_addr  = victim_addr;
				mem_wdata = victim_line;
				if (mem_ready) begin
					clean_victim = 1'b1;
					state_d      = st_allocate;
				end
			end

			st_allocate: begin
				mem_read = 1'b1;
				mem_addr = line_addr;
				if (mem_ready) begin
					// mem_rdata valid only now, so the fill lands on this edge
					fill_line = 1'b1;
					state_d   = st_compare;   // request hits next cycle
				end
			end

			default: begin
				state_d = st_idle;
			end
		endcase
	end

endmodule

/* verilog/cache_top.sv */
// cache top: two-way write-back cache between a word processor port and a line memory port
`timescale 1ns/10ps
module cache_top #(
	parameter int set_bits = 2
) (
	input  logic                                clk,
	input  logic                                proc_reset,
	// processor port
	input  logic                                proc_read,
	input  logic                                proc_write,
	input  logic [cache_pkg::addr_bits-1:0]     proc_addr,
	input  logic [cache_pkg::word_bits-1:0]     proc_wdata,
	output logic [cache_pkg::word_bits-1:0]     proc_rdata,
	output logic                                proc_stall,
	// memory port
	output logic                                mem_read,
	output logic                                mem_write,
	output logic [cache_pkg::mem_addr_bits-1:0] mem_addr,
	output logic [cache_pkg::line_bits-1:0]     mem_wdata,
	input  logic [cache_pkg::line_bits-1:0]     mem_rdata,
	input  logic                                mem_ready
);
	import cache_pkg::*;

	// ------------------------------------------------------------
	// storage to controller
	// ------------------------------------------------------------
	logic                                       hit;
	logic                                       victim_dirty;
	logic [addr_bits-offset_bits-set_bits-1:0] victim_tag;
	logic [line_bits-1:0]                       victim_line;

	// controller to storage, one-cycle update strobes
	logic write_word;
	logic fill_line;
	logic clean_victim;

	cache_ways #(
		.set_bits (set_bits)
	) i_ways (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_read),
		.proc_addr    (proc_addr),
		.proc_wdata   (proc_wdata),
		.mem_rdata    (mem_rdata),
		.write_word   (write_word),
		.fill_line    (fill_line),
		.clean_victim (clean_victim),
		.hit          (hit),
		.rdata        (proc_rdata),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.victim_line  (victim_line)
	);

	cache_ctrl #(
		.set_bits (set_bits)
	) i_ctrl (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_read),
		.proc_write   (proc_write),
		.proc_addr    (proc_addr),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.victim_line  (victim_line),
		.mem_ready    (mem_ready),
		.proc_stall   (proc_stall),
		.write_word   (write_word),
		.fill_line    (fill_line),
		.clean_victim (clean_victim),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata)
	);

endmodule

/* tests/slow_mem.sv */
// slow memory: line-wide model with fixed latency, one-cycle ready pulse and a word backdoor
`timescale 1ns/10ps
module slow_mem #(
	parameter int latency = 3
) (
	input  logic                                clk,
	input  logic                                proc_reset,
	input  logic                                mem_read,
	input  logic                                mem_write,
	input  logic [cache_pkg::mem_addr_bits-1:0] mem_addr,
	input  logic [cache_pkg::line_bits-1:0]     mem_wdata,
	output logic [cache_pkg::line_bits-1:0]     mem_rdata,
	output logic                                mem_ready
);
	import cache_pkg::*;

	logic [word_bits-1:0] words [logic [addr_bits-1:0]];   // written words only
	int count;

	// contents of a word never written, mixes every address bit
	function automatic logic [word_bits-1:0] fill_word(input logic [addr_bits-1:0] a);
		return {2'b10, a} ^ (32'(a) * 32'h9e37_79b1);
	endfunction

	// backdoor, current contents of one word
	function logic [word_bits-1:0] peek_word(input logic [addr_bits-1:0] a);
		if (words.exists(a)) begin
			return words[a];
		end
		return fill_word(a);
	endfunction

	always @(posedge clk) begin
		if (proc_reset) begin
			count     <= 0;
			mem_ready <= 1'b0;
			mem_rdata <= '0;
		end else if (mem_ready) begin
			mem_ready <= 1'b0;   // pulse lasts one cycle
			count     <= 0;
			if (mem_write) begin
				for (int w = 0; w < line_words; w++) begin
					words[{mem_addr, offset_bits'(w)}] = mem_wdata[w*word_bits +: word_bits];
				end
			end
		end else if (mem_read || mem_write) begin
			if (count == latency - 1) begin
				mem_ready <= 1'b1;
				for (int w = 0; w < line_words; w++) begin
					mem_rdata[w*word_bits +: word_bits] <= peek_word({mem_addr, offset_bits'(w)});
				end
			end else begin
				count <= count + 1;
			end
		end
	end

endmodule

/* tests/cache_checker.sv */
// cache checker for memory port protocol, stall and reset behaviour of the cache top level
`timescale 1ns/10ps
module cache_checker (
	input  logic                                clk,
	input  logic                                proc_reset,
	input  logic                                proc_read,
	input  logic                                proc_write,
	input  logic                                proc_stall,
	input  logic                                mem_read,
	input  logic                                mem_write,
	input  logic [cache_pkg::mem_addr_bits-1:0] mem_addr,
	input  logic [cache_pkg::line_bits-1:0]     mem_wdata,
	input  logic                                mem_ready,
	input  cache_pkg::cache_state_t             state
);
	import cache_pkg::*;

	int fail_count = 0;   // assertion failures so far

	// ------------------------------------------------------------
	// memory port
	// ------------------------------------------------------------
	a_one_op: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write))
		else begin
			$error("mem_read and mem_write high in the same cycle");
			fail_count++;
		end

	a_read_hold: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read && !mem_ready) |=> mem_read && $stable(mem_addr))
		else begin
			$error("memory read dropped or changed before mem_ready");
			fail_count++;
		end

	a_write_hold: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_write && !mem_ready) |=> mem_write && $stable(mem_addr) && $stable(mem_wdata))
		else begin
			$error("memory write dropped or changed before mem_ready");
			fail_count++;
		end

	// processor must wait out any memory traffic
	a_stall: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read || mem_write) |-> proc_stall)
		else begin
			$error("memory request active while proc_stall is low");
			fail_count++;
		end

	// ------------------------------------------------------------
	// reset and idle
	// ------------------------------------------------------------
	a_reset: assert property (@(posedge clk)
		proc_reset |=> (state == st_idle) && proc_stall && !mem_read && !mem_write)
		else begin
			$error("controller not idle and stalled after reset");
			fail_count++;
		end

	a_idle_exit: assert property (@(posedge clk) disable iff (proc_reset)
		(state == st_idle) |=> (state == st_compare))
		else begin
			$error("controller stayed in idle");
			fail_count++;
		end

	a_no_request: assert property (@(posedge clk) disable iff (proc_reset)
		(state == st_compare && !proc_read && !proc_write) |-> !proc_stall)
		else begin
			$error("proc_stall high with no request");
			fail_count++;
		end

endmodule

bind cache_top cache_checker i_checker (
	.clk        (clk),
	.proc_reset (proc_reset),
	.proc_read  (proc_read),
	.proc_write (proc_write),
	.proc_stall (proc_stall),
	.mem_read   (mem_read),
	.mem_write  (mem_write),
	.mem_addr   (mem_addr),
	.mem_wdata  (mem_wdata),
	.mem_ready  (mem_ready),
	.state      (i_ctrl.state_q)
);

/* tests/cache_tb.sv */
// cache testbench driving directed and random processor traffic against a shadow memory
`timescale 1ns/10ps
module cache_tb;
	import cache_pkg::*;

	localparam int mem_latency  = 3;
	localparam int random_count = 200;
	localparam int num_accesses = 8 + random_count;
	// every access a dirty miss, doubled, plus reset and idle cycles
	localparam int timeout_cycles = num_accesses * 2 * (mem_latency + 2) * 2 + 16;

	logic                     clk = 1'b0;
	logic                     proc_reset;
	logic                     proc_read;
	logic                     proc_write;
	logic [addr_bits-1:0]     proc_addr;
	logic [word_bits-1:0]     proc_wdata;
	logic [word_bits-1:0]     proc_rdata;
	logic                     proc_stall;
	logic                     mem_read;
	logic                     mem_write;
	logic [mem_addr_bits-1:0] mem_addr;
	logic [line_bits-1:0]     mem_wdata;
	logic [line_bits-1:0]     mem_rdata;
	logic                     mem_ready;

	logic [word_bits-1:0] shadow [logic [addr_bits-1:0]];   // words the processor wrote

	int cycles = 0;
	int checks = 0;
	int failures = 0;
	int tests = 0;
	int test_checks = 0;
	int test_failures = 0;

	// memory traffic seen since the last clear
	int                       rd_count = 0;
	int                       wr_count = 0;
	int                       rd_cycle = 0;
	int                       wr_cycle = 0;
	logic [mem_addr_bits-1:0] wr_addr;
	logic [line_bits-1:0]     wr_data;

	cache_top i_dut (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	slow_mem #(
		.latency (mem_latency)
	) i_mem (
		.clk        (clk),
		.proc_reset (proc_reset),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: accesses still running after %0d cycles", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// sampled mid low phase away from both edges
	always begin
		@(negedge clk);
		#10;
		if (mem_ready && mem_write) begin
			wr_count++;
			wr_cycle = cycles;
			wr_addr  = mem_addr;
			wr_data  = mem_wdata;
		end
		if (mem_ready && mem_read) begin
			rd_count++;
			rd_cycle = cycles;
		end
	end

	// ------------------------------------------------------------
	// shadow model
	// ------------------------------------------------------------
	function automatic logic [word_bits-1:0] shadow_word(input logic [addr_bits-1:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return i_mem.fill_word(a);   // initial memory contents
	endfunction

	function automatic logic [line_bits-1:0] shadow_line(input logic [mem_addr_bits-1:0] la);
		logic [line_bits-1:0] data;
		for (int w = 0; w < line_words; w++) begin
			data[w*word_bits +: word_bits] = shadow_word({la, offset_bits'(w)});   // word 0 lowest
		end
		return data;
	endfunction

	// ------------------------------------------------------------
	// checks and bookkeeping
	// ------------------------------------------------------------
	task automatic check_word(input string name, input logic [word_bits-1:0] expected,
		input logic [word_bits-1:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			failures++;
		end
	endtask

	task automatic check_line(input string name, input logic [line_bits-1:0] expected,
		input logic [line_bits-1:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			failures++;
		end
	endtask

	task automatic start_test();
		test_checks   = checks;
		test_failures = failures;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %-10s %0d checks, %0d failed", name, checks - test_checks,
			failures - test_failures);
	endtask

	task automatic clear_log();
		rd_count = 0;
		wr_count = 0;
		rd_cycle = 0;
		wr_cycle = 0;
	endtask

	// one processor access held until proc_stall is low
	task automatic access(input logic write, input logic [addr_bits-1:0] addr,
		input logic [word_bits-1:0] wdata, output logic [word_bits-1:0] rdata,
		output int waits);
		waits = 0;
		@(negedge clk);
		proc_read  = ~write;
		proc_write = write;
		proc_addr  = addr;
		proc_wdata = wdata;
		#10;
		while (proc_stall) begin
			waits++;
			@(negedge clk);
			#10;
		end
		rdata = proc_rdata;   // access completes at the next rising edge
		if (write) begin
			shadow[addr] = wdata;
		end
	endtask

	initial begin
		logic [word_bits-1:0] got;
		logic [word_bits-1:0] data;
		logic [word_bits-1:0] expected;
		logic [addr_bits-1:0] addr;
		logic                 is_write;
		int                   waits;
		int                   total_failures;

		void'($urandom(89));
		proc_reset = 1'b1;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		proc_reset = 1'b0;
		repeat (3) @(negedge clk);   // idle cycle then compare with nothing asked

		// read miss then another word of the same line
		start_test();
		clear_log();
		expected = shadow_word(30'h104);
		access(1'b0, 30'h104, '0, got, waits);
		check_word("read_miss data", expected, got);
		check_word("read_miss fills", 1, rd_count);
		expected = shadow_word(30'h106);
		access(1'b0, 30'h106, '0, got, waits);
		check_word("read_hit data", expected, got);
		check_word("read_hit waits", 0, waits);
		check_word("read_hit fills", 1, rd_count);
		end_test("read_miss");

		// write hit into the cached line
		start_test();
		clear_log();
		data = $urandom;
		access(1'b1, 30'h105, data, got, waits);
		check_word("write_hit waits", 0, waits);
		access(1'b0, 30'h105, '0, got, waits);
		check_word("write_hit data", data, got);
		check_word("write_hit writebacks", 0, wr_count);
		end_test("write_hit");

		// three lines of set 2 with the first dirty and least recent
		start_test();
		addr = 30'h208;
		data = $urandom;
		access(1'b1, addr, data, got, waits);
		access(1'b0, 30'h218, '0, got, waits);
		clear_log();
		expected = shadow_word(30'h228);
		access(1'b0, 30'h228, '0, got, waits);
		check_word("evict data", expected, got);
		check_word("evict writebacks", 1, wr_count);
		check_word("evict wb addr", {4'h0, addr[addr_bits-1:offset_bits]}, {4'h0, wr_addr});
		check_line("evict wb line", shadow_line(addr[addr_bits-1:offset_bits]), wr_data);
		check_word("evict order", 1, (wr_cycle < rd_cycle) ? 1 : 0);
		check_word("evict fills", 1, rd_count);
		access(1'b0, addr, '0, got, waits);
		check_word("evict reload", data, got);
		end_test("evict");

		// 12 lines over 4 sets so evictions are frequent
		start_test();
		for (int i = 0; i < random_count; i++) begin
			addr     = 30'h300 + 30'($urandom_range(47, 0));
			data     = $urandom;
			is_write = ($urandom_range(1, 0) == 1);
			expected = shadow_word(addr);
			access(is_write, addr, data, got, waits);
			if (!is_write) begin
				check_word("random read", expected, got);
			end
		end
		end_test("random");

		@(negedge clk);
		proc_read  = 1'b0;
		proc_write = 1'b0;
		repeat (2) @(negedge clk);

		total_failures = failures + i_dut.i_checker.fail_count;
		$display("done: %0d tests, %0d checks, %0d failures", tests, checks, total_failures);
		if (total_failures == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* files.f */
verilog/cache_pkg.sv
verilog/cache_ways.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
tests/slow_mem.sv
tests/cache_checker.sv
tests/cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module cache_tb -o cache_sim \
	&& ./obj_dir/cache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "run did not complete"; exit 1; }
echo "run passed"
